/* common/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    // Major opcodes of the supported RV32I subset.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;  // SRL or SRA, picked by funct7.
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [3:0] ALU_ADD    = 4'd0;
    localparam logic [3:0] ALU_SUB    = 4'd1;
    localparam logic [3:0] ALU_SLL    = 4'd2;
    localparam logic [3:0] ALU_SLT    = 4'd3;
    localparam logic [3:0] ALU_SLTU   = 4'd4;
    localparam logic [3:0] ALU_XOR    = 4'd5;
    localparam logic [3:0] ALU_SRL    = 4'd6;
    localparam logic [3:0] ALU_SRA    = 4'd7;
    localparam logic [3:0] ALU_OR     = 4'd8;
    localparam logic [3:0] ALU_AND    = 4'd9;
    localparam logic [3:0] ALU_PASS_B = 4'd10;

    // Operand pairs for the ALU, five of them, so three bits.
    localparam logic [2:0] SEL_RR  = 3'd0;  // rs1, rs2.
    localparam logic [2:0] SEL_RI  = 3'd1;  // rs1, imm.
    localparam logic [2:0] SEL_ZI  = 3'd2;  // 0, imm.
    localparam logic [2:0] SEL_PC4 = 3'd3;  // pc, 4.
    localparam logic [2:0] SEL_PCI = 3'd4;  // pc, imm.

    localparam int IN_CREDITS  = 2;
    localparam int OUT_CREDITS = 2;
    localparam int IN_PTR_W    = $clog2(IN_CREDITS);
    localparam int OUT_CNT_W   = $clog2(OUT_CREDITS + 1);

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

endpackage

/* src/inst_decode.sv */
`timescale 1ns/100ps

module inst_decode (
    input  rv_pkg::inst_u                 inst,
    output logic [rv_pkg::REG_IDX_W-1:0]  rs1,
    output logic [rv_pkg::REG_IDX_W-1:0]  rs2,
    output logic [rv_pkg::REG_IDX_W-1:0]  rd,
    output logic [3:0]                    alu_op,
    output logic [2:0]                    op_sel,
    output logic                          wr_en,
    output logic                          illegal
);
    import rv_pkg::*;

    // Only register ops have SUB; bit 30 selects SRA for both formats.
    function automatic logic [3:0] f3_to_alu(input logic [2:0] f3,
                                             input logic       alt,
                                             input logic       reg_op);
        case (f3)
            F3_ADD_SUB: f3_to_alu = (alt && reg_op) ? ALU_SUB : ALU_ADD;
            F3_SLL:     f3_to_alu = ALU_SLL;
            F3_SLT:     f3_to_alu = ALU_SLT;
            F3_SLTU:    f3_to_alu = ALU_SLTU;
            F3_XOR:     f3_to_alu = ALU_XOR;
            F3_SR:      f3_to_alu = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      f3_to_alu = ALU_OR;
            F3_AND:     f3_to_alu = ALU_AND;
            default:    f3_to_alu = ALU_ADD;
        endcase
    endfunction

    assign rs1 = inst.r_fmt.rs1;
    assign rs2 = inst.r_fmt.rs2;
    assign rd  = inst.r_fmt.rd;

    always_comb begin
        alu_op  = ALU_ADD;
        op_sel  = SEL_RR;
        wr_en   = 1'b0;
        illegal = 1'b0;
        case (inst.r_fmt.opcode)
            OPC_OP: begin
                alu_op = f3_to_alu(inst.r_fmt.funct3, inst.r_fmt.funct7[5], 1'b1);
                wr_en  = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op = f3_to_alu(inst.i_fmt.funct3, inst.i_fmt.imm[10], 1'b0);
                op_sel = SEL_RI;
                wr_en  = 1'b1;
            end
            // Opcode alone fixes the operation here.
            OPC_LUI: begin
                op_sel = SEL_ZI;
                wr_en  = 1'b1;
            end
            OPC_AUIPC: begin
                op_sel = SEL_PCI;
                wr_en  = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                op_sel = SEL_PC4;  // Link value only.
                wr_en  = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

/* src/imm_gen.sv */
`timescale 1ns/100ps

module imm_gen (
    input  rv_pkg::inst_u            inst,
    output logic [rv_pkg::XLEN-1:0]  imm
);
    import rv_pkg::*;

    always_comb begin
        case (inst.r_fmt.opcode)
            OPC_OP_IMM, OPC_JALR: begin
                imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
            end
            OPC_LUI, OPC_AUIPC: begin
                imm = {inst.u_fmt.imm, 12'd0};
            end
            OPC_JAL: begin
                // Offset bits are scattered in the word, bit 0 is implied.
                imm = {{11{inst.j_fmt.imm20}},
                       inst.j_fmt.imm20,
                       inst.j_fmt.imm19_12,
                       inst.j_fmt.imm11,
                       inst.j_fmt.imm10_1,
                       1'b0};
            end
            default: imm = '0;  // R-type has no immediate.
        endcase
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::REG_IDX_W-1:0]  rs1,
    input  logic [rv_pkg::REG_IDX_W-1:0]  rs2,
    input  logic                          wr_en,
    input  logic [rv_pkg::REG_IDX_W-1:0]  wr_idx,
    input  logic [rv_pkg::XLEN-1:0]       wr_data,
    output logic [rv_pkg::XLEN-1:0]       rs1_value,
    output logic [rv_pkg::XLEN-1:0]       rs2_value
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [2**REG_IDX_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_IDX_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;  // x0 stays zero.
        end
    end

    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* exu/alu.sv */
`timescale 1ns/100ps

module alu (
    input  logic [rv_pkg::XLEN-1:0]  d1,
    input  logic [rv_pkg::XLEN-1:0]  d2,
    input  logic [3:0]               alu_op,
    output logic [rv_pkg::XLEN-1:0]  res
);
    import rv_pkg::*;

    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;

    assign shamt       = d2[4:0];
    assign lt_signed   = $signed(d1) < $signed(d2);
    assign lt_unsigned = d1 < d2;
    assign sum         = d1 + d2;
    assign diff        = d1 - d2;

    always_comb begin
        case (alu_op)
            ALU_ADD:    res = sum;
            ALU_SUB:    res = diff;
            ALU_SLL:    res = d1 << shamt;
            ALU_SLT:    res = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   res = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:    res = d1 ^ d2;
            ALU_SRL:    res = d1 >> shamt;
            ALU_SRA:    res = $unsigned($signed(d1) >>> shamt);
            ALU_OR:     res = d1 | d2;
            ALU_AND:    res = d1 & d2;
            ALU_PASS_B: res = d2;
            default:    res = '0;
        endcase
    end

endmodule

/* exu/exu.sv */
`timescale 1ns/100ps

module exu (
    input  logic [rv_pkg::XLEN-1:0]  pc,
    input  logic [2:0]               op_sel,
    input  logic [3:0]               alu_op,
    input  logic [rv_pkg::XLEN-1:0]  imm,
    input  logic [rv_pkg::XLEN-1:0]  rs1_value,
    input  logic [rv_pkg::XLEN-1:0]  rs2_value,
    output logic [rv_pkg::XLEN-1:0]  ex_result
);
    import rv_pkg::*;

    logic [XLEN-1:0] add_1;
    logic [XLEN-1:0] add_2;

    // Operand table per opcode class.
    //   OP      rs1 , rs2
    //   OP-IMM  rs1 , imm
    //   LUI     0   , imm
    //   AUIPC   pc  , imm
    //   JAL(R)  pc  , 4
    always_comb begin
        case (op_sel)
            SEL_RR: begin
                add_1 = rs1_value;
                add_2 = rs2_value;
            end
            SEL_RI: begin
                add_1 = rs1_value;
                add_2 = imm;
            end
            SEL_ZI: begin
                add_1 = '0;
                add_2 = imm;
            end
            SEL_PC4: begin
                add_1 = pc;
                add_2 = XLEN'(4);
            end
            SEL_PCI: begin
                add_1 = pc;
                add_2 = imm;
            end
            default: begin
                add_1 = '0;
                add_2 = '0;
            end
        endcase
    end

    alu alu_i0 (
        .d1     (add_1),
        .d2     (add_2),
        .alu_op (alu_op),
        .res    (ex_result)
    );

endmodule

/* src/exec_top.sv */
`timescale 1ns/100ps

module exec_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          inst_valid,
    input  logic [31:0]                   inst,
    input  logic [rv_pkg::XLEN-1:0]       pc,
    output logic                          inst_credit,
    output logic                          res_valid,
    output logic [rv_pkg::REG_IDX_W-1:0]  res_rd,
    output logic [rv_pkg::XLEN-1:0]       res_data,
    output logic                          res_illegal,
    input  logic                          res_credit
);
    import rv_pkg::*;

    logic [31:0]          inst_mem [IN_CREDITS];
    logic [XLEN-1:0]      pc_mem   [IN_CREDITS];
    logic [IN_PTR_W-1:0]  wr_ptr;
    logic [IN_PTR_W-1:0]  rd_ptr;
    logic [IN_PTR_W:0]    fifo_cnt;
    logic [OUT_CNT_W-1:0] out_cnt;
    logic                 fire;

    inst_u                head_inst;
    logic [XLEN-1:0]      head_pc;
    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rd;
    logic [3:0]           alu_op;
    logic [2:0]           op_sel;
    logic                 dec_wr_en;
    logic                 dec_illegal;
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      rs1_value;
    logic [XLEN-1:0]      rs2_value;
    logic [XLEN-1:0]      ex_result;
    logic                 rf_wr_en;

    assign head_inst = inst_mem[rd_ptr];
    assign head_pc   = pc_mem[rd_ptr];

    // Head retires when present and the sink has room.
    assign fire     = (fifo_cnt != '0) && (out_cnt != '0);
    assign rf_wr_en = fire && dec_wr_en && !dec_illegal && (rd != '0);

    // Upstream credits guarantee a free slot on every inst_valid.
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            inst_mem[wr_ptr] <= inst;
            pc_mem[wr_ptr]   <= pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fifo_cnt    <= '0;
            out_cnt     <= OUT_CNT_W'(OUT_CREDITS);
            inst_credit <= 1'b0;
            res_valid   <= 1'b0;
        end else begin
            if (inst_valid) begin
                wr_ptr <= wr_ptr + IN_PTR_W'(1);
            end
            if (fire) begin
                rd_ptr <= rd_ptr + IN_PTR_W'(1);
            end
            fifo_cnt    <= fifo_cnt + {{IN_PTR_W{1'b0}}, inst_valid}
                                    - {{IN_PTR_W{1'b0}}, fire};
            out_cnt     <= out_cnt + {{(OUT_CNT_W-1){1'b0}}, res_credit}
                                   - {{(OUT_CNT_W-1){1'b0}}, fire};  // Both may land together.
            inst_credit <= fire;
            res_valid   <= fire;
        end
    end

    // Illegal words report no destination and no data.
    always_ff @(posedge clk) begin
        if (fire) begin
            res_rd      <= dec_illegal ? '0 : rd;
            res_data    <= dec_illegal ? '0 : ex_result;
            res_illegal <= dec_illegal;
        end
    end

    inst_decode inst_decode_i0 (
        .inst    (head_inst),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .alu_op  (alu_op),
        .op_sel  (op_sel),
        .wr_en   (dec_wr_en),
        .illegal (dec_illegal)
    );

    imm_gen imm_gen_i0 (
        .inst (head_inst),
        .imm  (imm)
    );

    reg_file reg_file_i0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .wr_en     (rf_wr_en),
        .wr_idx    (rd),
        .wr_data   (ex_result),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    exu exu_i0 (
        .pc        (head_pc),
        .op_sel    (op_sel),
        .alu_op    (alu_op),
        .imm       (imm),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .ex_result (ex_result)
    );

endmodule

/* tests/tb_exec_top.sv */
`timescale 1ns/100ps

module tb_exec_top;
    import rv_pkg::*;

    typedef enum {SINK_FREE, SINK_HOLD, SINK_BURST} sink_mode_e;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 inst_valid;
    logic [31:0]          inst;
    logic [XLEN-1:0]      pc;
    logic                 inst_credit;
    logic                 res_valid;
    logic [REG_IDX_W-1:0] res_rd;
    logic [XLEN-1:0]      res_data;
    logic                 res_illegal;
    logic                 res_credit;

    int  seed = 72;
    int  max_cycles = 20 * 63 + 100;  // 63 instructions over all tests.
    int  cycle;
    int  sent_cnt;
    int  ret_cnt;
    int  valid_cnt;
    int  granted = OUT_CREDITS;
    int  owed;
    int  pat_idx;
    int  acc;
    bit  lat_check;
    logic give;
    logic burst_pat [64];
    sink_mode_e sink_mode = SINK_FREE;
    logic [XLEN-1:0] cur_pc = 32'h0000_1000;
    string cur_name;

    // Model state, touched only by the monitor.
    logic [XLEN-1:0]      model_regs [32];
    logic [REG_IDX_W-1:0] m_rd;
    logic [XLEN-1:0]      m_data;
    logic                 m_ill;
    string                e_name;

    logic [REG_IDX_W-1:0] exp_rd [$];
    logic [XLEN-1:0]      exp_data [$];
    logic                 exp_ill [$];
    string                exp_name [$];
    int                   accept_q [$];

    logic [2:0] f3_tab [10] = '{F3_ADD_SUB, F3_ADD_SUB, F3_SLL, F3_SLT, F3_SLTU,
                                F3_XOR, F3_SR, F3_SR, F3_OR, F3_AND};
    logic       alt_tab [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    exec_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .pc          (pc),
        .inst_credit (inst_credit),
        .res_valid   (res_valid),
        .res_rd      (res_rd),
        .res_data    (res_data),
        .res_illegal (res_illegal),
        .res_credit  (res_credit)
    );

    always #20 clk = ~clk;

    function automatic inst_u r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
        inst_u w;
        w.r_fmt.funct7 = f7;
        w.r_fmt.rs2    = rs2;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.funct3 = f3;
        w.r_fmt.rd     = rd;
        w.r_fmt.opcode = OPC_OP;
        return w;
    endfunction

    function automatic inst_u i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
        inst_u w;
        w.i_fmt.imm    = imm;
        w.i_fmt.rs1    = rs1;
        w.i_fmt.funct3 = f3;
        w.i_fmt.rd     = rd;
        w.i_fmt.opcode = opc;
        return w;
    endfunction

    function automatic inst_u u_word(input logic [19:0] imm, input logic [4:0] rd,
                                     input logic [6:0] opc);
        inst_u w;
        w.u_fmt.imm    = imm;
        w.u_fmt.rd     = rd;
        w.u_fmt.opcode = opc;
        return w;
    endfunction

    function automatic inst_u j_word(input logic [20:0] off, input logic [4:0] rd);
        inst_u w;
        w.j_fmt.imm20    = off[20];
        w.j_fmt.imm10_1  = off[10:1];
        w.j_fmt.imm11    = off[11];
        w.j_fmt.imm19_12 = off[19:12];
        w.j_fmt.rd       = rd;
        w.j_fmt.opcode   = OPC_JAL;
        return w;
    endfunction

    // RV32I integer semantics; SUB only exists for register operands.
    function automatic logic [XLEN-1:0] arith_ref(input logic [2:0] f3, input logic alt,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b,
                                                  input logic reg_op);
        logic [4:0]             sh;
        logic signed [XLEN-1:0] sa;
        sh = b[4:0];
        sa = a;
        case (f3)
            F3_ADD_SUB: return (alt && reg_op) ? a - b : a + b;
            F3_SLL:     return a << sh;
            F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     return a ^ b;
            F3_SR: begin
                if (alt) begin
                    return sa >>> sh;  // Sign bit fills from the left.
                end else begin
                    return a >> sh;
                end
            end
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    function automatic void ref_exec(input inst_u w, input logic [XLEN-1:0] at_pc,
                                     output logic [REG_IDX_W-1:0] rd,
                                     output logic [XLEN-1:0] data, output logic ill);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] i_imm;
        logic [XLEN-1:0] u_imm;
        a     = model_regs[w.r_fmt.rs1];
        b     = model_regs[w.r_fmt.rs2];
        i_imm = {{20{w.i_fmt.imm[11]}}, w.i_fmt.imm};
        u_imm = {w.u_fmt.imm, 12'h000};
        ill   = 1'b0;
        rd    = w.r_fmt.rd;
        data  = '0;
        case (w.r_fmt.opcode)
            OPC_OP:            data = arith_ref(w.r_fmt.funct3, w.r_fmt.funct7[5], a, b, 1'b1);
            OPC_OP_IMM:        data = arith_ref(w.i_fmt.funct3, w.i_fmt.imm[10], a, i_imm, 1'b0);
            OPC_LUI:           data = u_imm;
            OPC_AUIPC:         data = at_pc + u_imm;
            OPC_JAL, OPC_JALR: data = at_pc + 32'd4;  // Link value.
            default: begin
                ill = 1'b1;
                rd  = '0;
            end
        endcase
        if (!ill && rd != '0) begin
            model_regs[rd] = data;
        end
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s data expected 0x%08h actual 0x%08h",
                                name, expected, actual));
        end
    endtask

    task automatic check_rd(input string name, input logic [REG_IDX_W-1:0] expected,
                            input logic [REG_IDX_W-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s rd expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s illegal expected %b actual %b",
                                name, expected, actual));
        end
    endtask

    task automatic check_latency(input string name, input int actual);
        if (actual != 2) begin
            abort_run($sformatf("MISMATCH %s latency expected 2 actual %0d", name, actual));
        end
    endtask

    // Reference model, credit bookkeeping and compare run on the sampling edge.
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > max_cycles) begin
            abort_run($sformatf("Timeout after %0d cycles with results outstanding.", cycle));
        end
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
        end else begin
            if (inst_valid) begin
                ref_exec(inst, pc, m_rd, m_data, m_ill);
                exp_rd.push_back(m_rd);
                exp_data.push_back(m_data);
                exp_ill.push_back(m_ill);
                exp_name.push_back(cur_name);
                accept_q.push_back(cycle);
            end
            if (inst_credit) ret_cnt = ret_cnt + 1;
            if (res_credit) granted = granted + 1;
            if (res_valid) begin
                valid_cnt = valid_cnt + 1;
                if (exp_data.size() == 0) begin
                    abort_run("A result arrived with no instruction outstanding.");
                end else begin
                    e_name = exp_name.pop_front();
                    acc    = accept_q.pop_front();
                    check_flag(e_name, exp_ill.pop_front(), res_illegal);
                    check_rd(e_name, exp_rd.pop_front(), res_rd);
                    check_data(e_name, exp_data.pop_front(), res_data);
                    if (lat_check) check_latency(e_name, cycle - acc);
                end
            end
            if (valid_cnt > granted) abort_run("More results were sent than credits granted.");
            if (ret_cnt > sent_cnt) abort_run("More input credits returned than instructions sent.");
        end
    end

    // Downstream sink.
    initial begin
        res_credit = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n && res_valid) owed = owed + 1;
            #2;
            give = 1'b0;
            if (owed > 0) begin
                case (sink_mode)
                    SINK_FREE: give = 1'b1;
                    SINK_BURST: begin
                        give    = burst_pat[pat_idx];
                        pat_idx = (pat_idx + 1) % 64;
                    end
                    default: give = 1'b0;
                endcase
            end
            res_credit = give;
            if (give) owed = owed - 1;
        end
    end

    task automatic send(input inst_u w, input string name);
        while (IN_CREDITS - sent_cnt + ret_cnt == 0) begin
            @(posedge clk);
            #2;
        end
        inst_valid = 1'b1;
        inst       = w;
        pc         = cur_pc;
        cur_name   = name;
        sent_cnt   = sent_cnt + 1;
        @(posedge clk);
        #2;
        inst_valid = 1'b0;
        cur_pc     = cur_pc + 32'd4;
    endtask

    task automatic wait_drain();
        while (exp_data.size() != 0 || owed != 0) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic op_imm_seq();
        send(i_word(-12'sd1234, 5'd0, F3_ADD_SUB, 5'd1, OPC_OP_IMM), "addi");
        send(i_word(-12'sd1, 5'd1, F3_XOR, 5'd2, OPC_OP_IMM), "xori");
        send(i_word(-12'sd256, 5'd1, F3_OR, 5'd3, OPC_OP_IMM), "ori");
        send(i_word(-12'sd16, 5'd1, F3_AND, 5'd4, OPC_OP_IMM), "andi");
        send(i_word(-12'sd1, 5'd1, F3_SLT, 5'd5, OPC_OP_IMM), "slti");
        send(i_word(-12'sd1, 5'd1, F3_SLTU, 5'd6, OPC_OP_IMM), "sltiu");
        send(i_word(12'h003, 5'd1, F3_SLL, 5'd7, OPC_OP_IMM), "slli");
        send(i_word(12'h004, 5'd1, F3_SR, 5'd8, OPC_OP_IMM), "srli");
        send(i_word(12'h404, 5'd1, F3_SR, 5'd9, OPC_OP_IMM), "srai");
        send(i_word(12'h800, 5'd1, F3_ADD_SUB, 5'd10, OPC_OP_IMM), "addi_min");  // -2048.
    endtask

    task automatic rtype_seq();
        logic [31:0] rnd;
        logic [4:0]  prev;
        logic [4:0]  src2;
        logic [4:0]  dst;
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            dst = 5'(11 + i);
            send(u_word(rnd[31:12], dst, OPC_LUI), $sformatf("load_hi_%0d", i));
            send(i_word(rnd[11:0], dst, F3_ADD_SUB, dst, OPC_OP_IMM), $sformatf("load_lo_%0d", i));
        end
        prev = 5'd11;
        for (int i = 0; i < 20; i++) begin
            rnd  = $random(seed);
            src2 = 5'(11 + rnd[1:0]);
            dst  = 5'(11 + (rnd[6:4] % 3'd5));
            send(r_word(alt_tab[i % 10] ? 7'h20 : 7'h00, src2, prev, f3_tab[i % 10], dst),
                 $sformatf("rtype_%0d", i));
            prev = dst;  // Next op reads this result.
        end
    endtask

    task automatic upper_jump_seq();
        send(u_word(20'hABCDE, 5'd16, OPC_LUI), "lui");
        send(u_word(20'hFFFFF, 5'd17, OPC_AUIPC), "auipc");
        send(j_word(21'h1FFFF0, 5'd18), "jal");
        send(i_word(-12'sd4, 5'd16, 3'b000, 5'd19, OPC_JALR), "jalr");
        send(u_word(20'h12345, 5'd0, OPC_LUI), "x0_write");
        send(r_word(7'h00, 5'd0, 5'd0, F3_ADD_SUB, 5'd20), "x0_read");
    endtask

    task automatic illegal_seq();
        send(i_word(12'd77, 5'd0, F3_ADD_SUB, 5'd21, OPC_OP_IMM), "ill_setup");
        send(i_word(12'h055, 5'd1, 3'b010, 5'd21, 7'b0000011), "ill_load");
        send(r_word(7'h00, 5'd0, 5'd21, F3_ADD_SUB, 5'd22), "ill_readback");
    endtask

    task automatic backpressure_seq();
        logic [31:0] rnd;
        inst_u       bp_inst [12];
        for (int g = 0; g < 16; g++) begin
            rnd = $random(seed);
            for (int j = 0; j < 4; j++) begin
                burst_pat[g * 4 + j] = (g == 15) || (rnd[1:0] != 2'b00);
            end
        end
        for (int i = 0; i < 12; i++) begin
            rnd = $random(seed);
            if (i % 2 == 0) begin
                bp_inst[i] = i_word(rnd[11:0], 5'(11 + (i + 1) % 4), F3_ADD_SUB, 5'(11 + i % 4),
                                    OPC_OP_IMM);
            end else begin
                bp_inst[i] = r_word(7'h20, 5'(11 + rnd[1:0]), 5'(11 + (i + 3) % 4),
                                    F3_ADD_SUB, 5'(11 + i % 4));
            end
        end
        sink_mode = SINK_HOLD;
        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    send(bp_inst[i], $sformatf("bp_%0d", i));
                end
            end
            begin
                repeat (30) @(posedge clk);
                sink_mode = SINK_BURST;
            end
        join
        wait_drain();
        sink_mode = SINK_FREE;
    endtask

    task automatic latency_seq();
        wait_drain();
        lat_check = 1'b1;
        send(i_word(12'd1, 5'd0, F3_ADD_SUB, 5'd23, OPC_OP_IMM), "lat_0");
        send(i_word(12'd2, 5'd23, F3_ADD_SUB, 5'd24, OPC_OP_IMM), "lat_1");
        send(r_word(7'h00, 5'd23, 5'd24, F3_ADD_SUB, 5'd25), "lat_2");
        send(r_word(7'h00, 5'd24, 5'd25, F3_OR, 5'd26), "lat_3");
        wait_drain();
        lat_check = 1'b0;
    endtask

    initial begin
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        op_imm_seq();
        rtype_seq();
        upper_jump_seq();
        illegal_seq();
        backpressure_seq();
        latency_seq();
        wait_drain();
        repeat (4) @(posedge clk);
        if (exp_data.size() == 0 && valid_cnt == sent_cnt) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run("Not every instruction produced a result.");
        end
    end

endmodule

/* list.f */
common/rv_pkg.sv
src/inst_decode.sv
src/imm_gen.sv
src/reg_file.sv
exu/alu.sv
exu/exu.sv
src/exec_top.sv
tests/tb_exec_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator and run; the exit status follows the simulation.
cd "$(dirname "$0")" &&
verilator --binary --timing -f list.f --top-module tb_exec_top \
    --Mdir obj_dir -o tb_exec_top &&
./obj_dir/tb_exec_top ||
{ echo "Simulation failed" >&2; exit 1; }
